/* logic/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    typedef logic [31:0] wordT;    // Data or instruction word
    typedef logic [4:0]  regAddrT; // Register index
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;

    // Major opcodes of the supported subset
    localparam opcodeT OpReg   = 7'b0110011;
    localparam opcodeT OpImm   = 7'b0010011;
    localparam opcodeT OpLoad  = 7'b0000011;
    localparam opcodeT OpStore = 7'b0100011;

    // funct3 codes for the ALU functions
    localparam funct3T F3AddSub = 3'b000;
    localparam funct3T F3Sll    = 3'b001;
    localparam funct3T F3Slt    = 3'b010;
    localparam funct3T F3Xor    = 3'b100;
    localparam funct3T F3Srl    = 3'b101;
    localparam funct3T F3Or     = 3'b110;
    localparam funct3T F3And    = 3'b111;

    // funct7 bit that turns add into sub and srl into sra
    localparam int Funct7AltBit = 30;

endpackage

`default_nettype wire

/* logic/cpuCtrlPkg.sv */
`default_nettype none

package cpuCtrlPkg;
    import rvIsaPkg::*;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSll,
        AluSrl
    } aluOpT;

    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;   // Immediate as second operand
        logic  memWrite;
        logic  memToReg;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
        wordT    imm; // Sign extended
    } decodedT;

endpackage

`default_nettype wire

/* logic/instFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instFetch import rvIsaPkg::*; #(
    parameter int IMemWords = 64
) (
    input  wire  CLK,
    input  wire  RST,
    input  logic imemWe,
    input  wordT imemAddr,
    input  wordT imemData,
    output wordT pc,
    output wordT inst
);

    localparam int IAddrBits = $clog2(IMemWords);

    wordT mem [IMemWords];

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // Boot loader writes only while the core is held in reset
    always_ff @(posedge CLK) begin
        if (RST && imemWe) begin
            mem[imemAddr[IAddrBits+1:2]] <= imemData;
        end
    end

    assign inst = mem[pc[IAddrBits+1:2]]; // Word address

endmodule

`default_nettype wire

/* logic/mainDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module mainDecode import rvIsaPkg::*; import cpuCtrlPkg::*; (
    input  wire     RST,
    input  wordT    inst,
    output decodedT dec,
    output ctrlT    ctrl
);

    opcodeT opcode;
    funct3T funct3;
    logic   alt; // Bit 30 selects sub

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[Funct7AltBit];

    assign dec.rs1 = inst[19:15];
    assign dec.rs2 = inst[24:20];
    assign dec.rd  = inst[11:7];

    always_comb begin
        case (opcode)
            OpImm, OpLoad: dec.imm = {{20{inst[31]}}, inst[31:20]};
            OpStore:       dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            default:       dec.imm = '0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            OpReg: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    F3AddSub: ctrl.aluOp = alt ? AluSub : AluAdd;
                    F3Sll:    ctrl.aluOp = AluSll;
                    F3Slt:    ctrl.aluOp = AluSlt;
                    F3Xor:    ctrl.aluOp = AluXor;
                    F3Srl:    begin
                        ctrl.aluOp    = AluSrl;
                        ctrl.regWrite = !alt; // No sra
                    end
                    F3Or:     ctrl.aluOp = AluOr;
                    F3And:    ctrl.aluOp = AluAnd;
                    default:  ctrl.regWrite = 1'b0;
                endcase
            end
            OpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                case (funct3)
                    F3AddSub: ctrl.aluOp = AluAdd;
                    F3Slt:    ctrl.aluOp = AluSlt;
                    F3Xor:    ctrl.aluOp = AluXor;
                    F3Or:     ctrl.aluOp = AluOr;
                    F3And:    ctrl.aluOp = AluAnd;
                    default:  ctrl = '0; // Immediate shifts retire as no-op
                endcase
            end
            OpLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            OpStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            default: ctrl = '0;
        endcase
        // Nothing retires while the program is being loaded
        if (RST) begin
            ctrl = '0;
        end
    end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import rvIsaPkg::*; (
    input  wire     CLK,
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  regAddrT rd,
    input  logic    we,
    input  wordT    wd,
    output wordT    rd1,
    output wordT    rd2
);

    wordT regs [1:31]; // x0 has no storage

    always_ff @(posedge CLK) begin
        if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* logic/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit import rvIsaPkg::*; import cpuCtrlPkg::*; (
    input  ctrlT ctrl,
    input  wordT a,
    input  wordT b,
    input  wordT imm,
    output wordT result
);

    wordT opB;
    logic [4:0] shamt;

    assign opB   = ctrl.aluSrc ? imm : b;
    assign shamt = opB[4:0]; // Low five bits only

    always_comb begin
        case (ctrl.aluOp)
            AluAdd:  result = a + opB;
            AluSub:  result = a - opB;
            AluAnd:  result = a & opB;
            AluOr:   result = a | opB;
            AluXor:  result = a ^ opB;
            AluSlt:  result = ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
            AluSll:  result = a << shamt;
            AluSrl:  result = a >> shamt; // Logical
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem import rvIsaPkg::*; #(
    parameter int DMemWords = 64
) (
    input  wire  CLK,
    input  wordT addr,
    input  logic we,
    input  wordT wd,
    output wordT rdata
);

    localparam int DAddrBits = $clog2(DMemWords);

    wordT mem [DMemWords];
    logic [DAddrBits-1:0] wordAddr;

    assign wordAddr = addr[DAddrBits+1:2];

    // Start from a cleared memory
    initial begin
        for (int i = 0; i < DMemWords; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordAddr] <= wd;
        end
    end

    assign rdata = mem[wordAddr];

endmodule

`default_nettype wire

/* logic/singleCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module singleCpu import rvIsaPkg::*; import cpuCtrlPkg::*; #(
    parameter int IMemWords = 64,
    parameter int DMemWords = 64
) (
    input  wire     CLK,
    input  wire     RST,
    input  logic    imemWe,
    input  wordT    imemAddr,
    input  wordT    imemData,
    output wordT    OUT,
    output logic    wbValid,
    output regAddrT wbReg,
    output wordT    wbData
);

    wordT    pc;
    wordT    inst;
    decodedT dec;
    ctrlT    ctrl;
    wordT    rd1;
    wordT    rd2;
    wordT    aluResult;
    wordT    loadData;
    wordT    wbSel;

    instFetch #(.IMemWords(IMemWords)) u_instFetch (
        .CLK(CLK), .RST(RST),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .pc(pc), .inst(inst)
    );

    mainDecode u_mainDecode (.RST(RST), .inst(inst), .dec(dec), .ctrl(ctrl));

    regFile u_regFile (
        .CLK(CLK), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .we(ctrl.regWrite), .wd(wbSel),
        .rd1(rd1), .rd2(rd2)
    );

    execUnit u_execUnit (.ctrl(ctrl), .a(rd1), .b(rd2), .imm(dec.imm), .result(aluResult));

    dataMem #(.DMemWords(DMemWords)) u_dataMem (
        .CLK(CLK), .addr(aluResult), .we(ctrl.memWrite), .wd(rd2), .rdata(loadData)
    );

    // Write-back source
    assign wbSel = ctrl.memToReg ? loadData : aluResult;

    assign OUT     = inst;
    assign wbValid = ctrl.regWrite && (dec.rd != '0); // x0 writes are not traced
    assign wbReg   = dec.rd;
    assign wbData  = wbSel;

endmodule

`default_nettype wire

/* test/singleCpu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module singleCpuSva import rvIsaPkg::*; import cpuCtrlPkg::*; (
    input wire     CLK,
    input wire     RST,
    input wordT    pc,
    input wordT    inst,
    input ctrlT    ctrl,
    input logic    wbValid,
    input regAddrT wbReg
);

    // Trace never reports x0
    wbRegNonZero: assert property (@(posedge CLK) wbValid |-> wbReg != '0)
        else $error("wbValid raised with wbReg zero");

    pcStep: assert property (@(posedge CLK) disable iff (RST)
        !$past(RST) |-> pc == $past(pc) + 32'd4)
        else $error("Program counter did not advance by four");

    storeNoWrite: assert property (@(posedge CLK) (inst[6:0] == OpStore) |-> !ctrl.regWrite)
        else $error("Store asserted regWrite");

endmodule

bind singleCpu singleCpuSva u_singleCpuSva (
    .CLK(CLK), .RST(RST), .pc(pc), .inst(inst), .ctrl(ctrl),
    .wbValid(wbValid), .wbReg(wbReg)
);

`default_nettype wire

/* test/tbSingleCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tbSingleCpu import rvIsaPkg::*; ();

    localparam int Period      = 100;
    localparam int ResetCycles = 8;
    localparam int NumTests    = 5;
    localparam int ProgMax     = 32; // Longest program of any test
    // Each word costs one load cycle and one run cycle
    localparam int WatchdogNs  = (ResetCycles + NumTests * 2 * ProgMax) * Period * 2;
    localparam opcodeT OpIllegal = 7'b1111111;

    logic    CLK;
    logic    RST;
    logic    imemWe;
    wordT    imemAddr;
    wordT    imemData;
    wordT    OUT;
    logic    wbValid;
    regAddrT wbReg;
    wordT    wbData;

    integer  seed = 32'h2bce31a3;
    string   testName;
    wordT    shadow [32] = '{default: '0};    // Architectural register model
    wordT    shadowMem [64] = '{default: '0}; // Data memory model
    wordT    prog [$];
    logic    expValid [$];
    regAddrT expReg [$];
    wordT    expData [$];

    singleCpu #(.IMemWords(64), .DMemWords(64)) u_singleCpu (
        .CLK(CLK), .RST(RST), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .OUT(OUT), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    initial begin
        CLK = 1'b0;
        forever #(Period / 2) CLK = ~CLK;
    end

    initial begin
        #(WatchdogNs);
        $display("Watchdog expired after %0d ns, the run hung", WatchdogNs);
        $display("SIMULATION FAILED");
        $fatal(1, "Timeout");
    end

    function automatic wordT sext(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic wordT encI(logic [11:0] imm, regAddrT rs1, funct3T f3, regAddrT rd,
                                  opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT encS(logic [11:0] imm, regAddrT rs2, regAddrT rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpStore}; // sw
    endfunction

    // Expected value from the RV32I definitions
    function automatic wordT isaResult(funct3T f3, logic alt, wordT a, wordT b);
        case (f3)
            F3AddSub: return alt ? a - b : a + b;
            F3Sll:    return a << b[4:0];
            F3Slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3Xor:    return a ^ b;
            F3Srl:    return a >> b[4:0];
            F3Or:     return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic regAddrT pickReg(int first, int count);
        return regAddrT'(first + ({$random(seed)} % count));
    endfunction

    function automatic void retire(wordT word, logic valid, regAddrT rd, wordT data);
        prog.push_back(word);
        expValid.push_back(valid);
        expReg.push_back(rd);
        expData.push_back(data);
        if (valid) begin
            shadow[rd] = data;
        end
    endfunction

    function automatic void emitImm(funct3T f3, regAddrT rd, regAddrT rs1, logic [11:0] imm);
        retire(encI(imm, rs1, f3, rd, OpImm), rd != '0, rd,
               isaResult(f3, 1'b0, shadow[rs1], sext(imm)));
    endfunction

    function automatic void emitReg(funct3T f3, logic alt, regAddrT rd, regAddrT rs1,
                                    regAddrT rs2);
        retire({1'b0, alt, 5'b0, rs2, rs1, f3, rd, OpReg}, rd != '0, rd,
               isaResult(f3, alt, shadow[rs1], shadow[rs2]));
    endfunction

    function automatic void emitStore(regAddrT rs2, regAddrT rs1, logic [11:0] imm);
        wordT addr;
        addr = shadow[rs1] + sext(imm);
        shadowMem[addr[7:2]] = shadow[rs2]; // Word address in 64 words
        retire(encS(imm, rs2, rs1), 1'b0, '0, '0);
    endfunction

    function automatic void emitLoad(regAddrT rd, regAddrT rs1, logic [11:0] imm);
        wordT addr;
        addr = shadow[rs1] + sext(imm);
        retire(encI(imm, rs1, 3'b010, rd, OpLoad), rd != '0, rd, shadowMem[addr[7:2]]);
    endfunction

    task automatic checkEq(string what, wordT expected, wordT actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h, actual %h", testName, what, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch in %s", testName);
        end
    endtask

    task automatic newProgram(string name);
        testName = name;
        prog.delete();
        expValid.delete();
        expReg.delete();
        expData.delete();
    endtask

    // Boot loader writes one word per cycle while the core is held in reset
    task automatic loadProgram();
        RST = 1'b1;
        foreach (prog[i]) begin
            imemWe   = 1'b1;
            imemAddr = wordT'(i * 4);
            imemData = prog[i];
            @(posedge CLK);
            #1;
        end
        imemWe = 1'b0;
        RST    = 1'b0;
    endtask

    task automatic runProgram();
        loadProgram();
        foreach (prog[i]) begin
            @(negedge CLK); // Mid cycle where outputs have settled
            checkEq("OUT", prog[i], OUT);
            checkEq("wbValid", {31'b0, expValid[i]}, {31'b0, wbValid});
            if (expValid[i]) begin
                checkEq("wbReg", {27'b0, expReg[i]}, {27'b0, wbReg});
                checkEq("wbData", expData[i], wbData);
            end
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic traceTest();
        newProgram("trace");
        for (int i = 1; i <= 6; i++) begin
            emitImm(F3AddSub, regAddrT'(i), 5'd0, 12'($random(seed)));
        end
        runProgram();
    endtask

    task automatic immTest();
        funct3T ops [5] = '{F3AddSub, F3And, F3Or, F3Xor, F3Slt};
        newProgram("immArith");
        for (int r = 1; r <= 4; r++) begin
            emitImm(F3AddSub, regAddrT'(r), 5'd0, 12'($random(seed)));
        end
        for (int k = 0; k < 4; k++) begin
            foreach (ops[j]) begin
                emitImm(ops[j], pickReg(1, 31), pickReg(1, 4), 12'($random(seed)));
            end
        end
        runProgram();
    endtask

    task automatic regTest();
        funct3T ops [8] = '{F3AddSub, F3AddSub, F3And, F3Or, F3Xor, F3Slt, F3Sll, F3Srl};
        logic   alts [8] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        newProgram("regArith");
        for (int r = 1; r <= 6; r++) begin
            emitImm(F3AddSub, regAddrT'(r), 5'd0, 12'($random(seed)));
        end
        for (int k = 0; k < 3; k++) begin
            foreach (ops[j]) begin
                emitReg(ops[j], alts[j], pickReg(1, 31), pickReg(1, 6), pickReg(1, 6));
            end
        end
        runProgram();
    endtask

    task automatic memTest();
        int words [4];
        newProgram("memory");
        emitImm(F3AddSub, 5'd10, 5'd0, 12'd64); // Base so offsets can be negative
        for (int k = 0; k < 4; k++) begin
            words[k] = k * 16 + ({$random(seed)} % 16);
            emitImm(F3AddSub, regAddrT'(11 + k), 5'd0, 12'($random(seed)));
            emitStore(regAddrT'(11 + k), 5'd10, 12'(words[k] * 4 - 64));
        end
        for (int k = 0; k < 4; k++) begin
            emitLoad(regAddrT'(20 + k), 5'd10, 12'(words[k] * 4 - 64));
        end
        runProgram();
    endtask

    task automatic x0Test();
        newProgram("x0Illegal");
        emitImm(F3AddSub, 5'd5, 5'd0, 12'($random(seed)));
        emitImm(F3AddSub, 5'd0, 5'd5, 12'($random(seed))); // No trace
        emitReg(F3AddSub, 1'b0, 5'd6, 5'd0, 5'd0);
        retire(encI(12'($random(seed)), 5'd5, 3'b000, 5'd5, OpIllegal), 1'b0, '0, '0);
        emitReg(F3AddSub, 1'b0, 5'd7, 5'd5, 5'd0);        // x5 untouched
        emitReg(F3Or, 1'b0, 5'd8, 5'd0, 5'd5);
        runProgram();
    endtask

    initial begin
        RST      = 1'b1;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        repeat (ResetCycles) @(posedge CLK);
        #1;
        traceTest();
        immTest();
        regTest();
        memTest();
        x0Test();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* singleCpu.f */
logic/rvIsaPkg.sv
logic/cpuCtrlPkg.sv
logic/instFetch.sv
logic/mainDecode.sv
logic/regFile.sv
logic/execUnit.sv
logic/dataMem.sv
logic/singleCpu.sv
test/singleCpu_sva.sv
test/tbSingleCpu.sv

/* Bender.yml */
package:
  name: singleCpu

sources:
  - logic/rvIsaPkg.sv
  - logic/cpuCtrlPkg.sv
  - logic/instFetch.sv
  - logic/mainDecode.sv
  - logic/regFile.sv
  - logic/execUnit.sv
  - logic/dataMem.sv
  - logic/singleCpu.sv
  - target: test
    files:
      - test/singleCpu_sva.sv
      - test/tbSingleCpu.sv
